// File: design/xoff_pkg.sv
/*
  Shared types and constants for the Zbb offload path.
  Widths are fixed by RV32, so nothing here is meant to be overridden.
  Encodings follow the ratified Zbb extension. Only RV32 forms are kept.
  BUF_DEPTH sizes both the result FIFO and the credit counter.
  CREDIT_W must hold the value BUF_DEPTH itself.
*/
`default_nettype none

package xoff_pkg;

  typedef logic [31:0] xlen_t;
  typedef logic [31:0] instr_t;
  typedef logic [4:0]  reg_idx_t;

  // Result FIFO depth and matching credit counter
  localparam int BUF_DEPTH = 4;
  localparam int CREDIT_W  = 3;

  typedef logic [CREDIT_W-1:0] credit_t;

  typedef enum logic [3:0] {
    BM_NONE,
    BM_ANDN,
    BM_ORN,
    BM_XNOR,
    BM_MIN,
    BM_MAX,
    BM_MINU,
    BM_MAXU,
    BM_ROL,
    BM_ROR,
    BM_CLZ,
    BM_CTZ,
    BM_CPOP,
    BM_REV8
  } bm_op_e;

  // Major opcodes
  localparam logic [6:0] OPC_OP     = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM = 7'b0010011;

  // funct7 groups of the register-register forms
  localparam logic [6:0] F7_ANDN   = 7'b0100000;
  localparam logic [6:0] F7_MINMAX = 7'b0000101;
  localparam logic [6:0] F7_ROT    = 7'b0110000;

  // funct3 selectors within each group
  localparam logic [2:0] F3_ANDN  = 3'b111;
  localparam logic [2:0] F3_ORN   = 3'b110;
  localparam logic [2:0] F3_XNOR  = 3'b100;
  localparam logic [2:0] F3_MIN   = 3'b100;
  localparam logic [2:0] F3_MINU  = 3'b101;
  localparam logic [2:0] F3_MAX   = 3'b110;
  localparam logic [2:0] F3_MAXU  = 3'b111;
  localparam logic [2:0] F3_ROL   = 3'b001;
  localparam logic [2:0] F3_ROR   = 3'b101;
  localparam logic [2:0] F3_COUNT = 3'b001;
  localparam logic [2:0] F3_REV8  = 3'b101;

  // Immediate of clz; ctz and cpop add 1 and 2 in the low bits
  localparam logic [11:0] F7_COUNT = 12'h600;
  localparam logic [11:0] REV8_IMM = 12'h698;

endpackage

`default_nettype wire

// File: design/xoff_predecoder.sv
/*
  Combinational decode of one instruction word into a Zbb operation.
  Only the thirteen kept encodings are recognised. Every other word,
  including the Zbb forms left out here (rori, sext, zext, orc.b),
  decodes to BM_NONE and is not accepted.
*/
`default_nettype none

module xoff_predecoder (
  input  xoff_pkg::instr_t instr_i,
  output xoff_pkg::bm_op_e op_o,
  output logic             accept_o
);

  logic [6:0]  opcode;
  logic [2:0]  funct3;
  logic [6:0]  funct7;
  logic [11:0] imm;

  assign opcode = instr_i[6:0];
  assign funct3 = instr_i[14:12];
  assign funct7 = instr_i[31:25];
  assign imm    = instr_i[31:20];

  always_comb begin
    op_o = xoff_pkg::BM_NONE;
    if (opcode == xoff_pkg::OPC_OP) begin
      case ({funct7, funct3})
        {xoff_pkg::F7_ANDN, xoff_pkg::F3_ANDN}:   op_o = xoff_pkg::BM_ANDN;
        {xoff_pkg::F7_ANDN, xoff_pkg::F3_ORN}:    op_o = xoff_pkg::BM_ORN;
        {xoff_pkg::F7_ANDN, xoff_pkg::F3_XNOR}:   op_o = xoff_pkg::BM_XNOR;
        {xoff_pkg::F7_MINMAX, xoff_pkg::F3_MIN}:  op_o = xoff_pkg::BM_MIN;
        {xoff_pkg::F7_MINMAX, xoff_pkg::F3_MINU}: op_o = xoff_pkg::BM_MINU;
        {xoff_pkg::F7_MINMAX, xoff_pkg::F3_MAX}:  op_o = xoff_pkg::BM_MAX;
        {xoff_pkg::F7_MINMAX, xoff_pkg::F3_MAXU}: op_o = xoff_pkg::BM_MAXU;
        {xoff_pkg::F7_ROT, xoff_pkg::F3_ROL}:     op_o = xoff_pkg::BM_ROL;
        {xoff_pkg::F7_ROT, xoff_pkg::F3_ROR}:     op_o = xoff_pkg::BM_ROR;
        default:                                  op_o = xoff_pkg::BM_NONE;
      endcase
    end else if (opcode == xoff_pkg::OPC_OP_IMM) begin
      // Unary forms carry the whole selector in the immediate
      case ({funct3, imm})
        {xoff_pkg::F3_COUNT, xoff_pkg::F7_COUNT}: begin
          op_o = xoff_pkg::BM_CLZ;
        end
        {xoff_pkg::F3_COUNT, xoff_pkg::F7_COUNT + 12'd1}: begin
          op_o = xoff_pkg::BM_CTZ;
        end
        {xoff_pkg::F3_COUNT, xoff_pkg::F7_COUNT + 12'd2}: begin
          op_o = xoff_pkg::BM_CPOP;
        end
        {xoff_pkg::F3_REV8, xoff_pkg::REV8_IMM}: begin
          op_o = xoff_pkg::BM_REV8;
        end
        default: begin
          op_o = xoff_pkg::BM_NONE;
        end
      endcase
    end
  end

  assign accept_o = (op_o != xoff_pkg::BM_NONE);

endmodule

`default_nettype wire

// File: design/xoff_adapter.sv
/*
  Request side of the offload path.
  k_accept_o and k_writeback_o answer combinationally and are only
  meaningful while q_valid_i and q_ready_o are both high.
  Rejected words finish their handshake and are dropped.
  q_ready_o stays high while at least one FIFO slot is free, counting
  results still in the pipeline as taken.
*/
`default_nettype none

module xoff_adapter (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               q_valid_i,
  output logic               q_ready_o,
  input  xoff_pkg::instr_t   q_instr_i,
  input  xoff_pkg::xlen_t    q_rs1_i,
  input  xoff_pkg::xlen_t    q_rs2_i,
  output logic               k_accept_o,
  output logic               k_writeback_o,
  output logic               issue_valid_o,
  output xoff_pkg::bm_op_e   issue_op_o,
  output xoff_pkg::reg_idx_t issue_rd_o,
  output xoff_pkg::xlen_t    issue_a_o,
  output xoff_pkg::xlen_t    issue_b_o,
  input  logic               credit_ret_i
);

  xoff_pkg::bm_op_e  dec_op;
  logic              dec_accept;
  logic              q_xfer;
  logic              issue_en;
  xoff_pkg::credit_t credits_q;

  xoff_predecoder u_predecoder (
    .instr_i  (q_instr_i),
    .op_o     (dec_op),
    .accept_o (dec_accept)
  );

  assign q_ready_o     = (credits_q != '0);
  assign q_xfer        = q_valid_i & q_ready_o;
  assign issue_en      = q_xfer & dec_accept;

  // Every kept operation writes rd
  assign k_accept_o    = dec_accept;
  assign k_writeback_o = dec_accept;

  // One credit per free result slot
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      credits_q <= xoff_pkg::credit_t'(xoff_pkg::BUF_DEPTH);
    end else begin
      case ({issue_en, credit_ret_i})
        2'b10:   credits_q <= credits_q - 1'b1;
        2'b01:   credits_q <= credits_q + 1'b1;
        default: credits_q <= credits_q;
      endcase
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      issue_valid_o <= 1'b0;
    end else begin
      issue_valid_o <= issue_en;
    end
  end

  always_ff @(posedge clk_i) begin
    if (issue_en) begin
      issue_op_o <= dec_op;
      issue_rd_o <= q_instr_i[11:7];
      issue_a_o  <= q_rs1_i;
      issue_b_o  <= q_rs2_i;
    end
  end

  // Credits come back from the FIFO, so the count bounds what is outstanding
  a_credit_bound: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    credits_q <= xoff_pkg::credit_t'(xoff_pkg::BUF_DEPTH));

  a_no_spurious_ret: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    credit_ret_i |-> credits_q != xoff_pkg::credit_t'(xoff_pkg::BUF_DEPTH));

endmodule

`default_nettype wire

// File: design/xoff_bitmanip.sv
/*
  Two-stage Zbb datapath that never stalls. A result appears two cycles
  after its issue strobe. Stage 1 does the word-wide operations and
  per-byte counts, stage 2 folds the counts and picks the result.
  Rotates use only b[4:0]. Count operations ignore b.
*/
`default_nettype none

module xoff_bitmanip (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               in_valid_i,
  input  xoff_pkg::bm_op_e   op_i,
  input  xoff_pkg::reg_idx_t rd_i,
  input  xoff_pkg::xlen_t    a_i,
  input  xoff_pkg::xlen_t    b_i,
  output logic               out_valid_o,
  output xoff_pkg::reg_idx_t out_rd_o,
  output xoff_pkg::xlen_t    out_data_o
);

  // Leading zeros of one byte, 8 when the byte is zero
  function automatic logic [3:0] byte_lz(input logic [7:0] b);
    logic [3:0] n;
    logic       seen;
    n    = 4'd0;
    seen = 1'b0;
    for (int i = 7; i >= 0; i--) begin
      seen = seen | b[i];
      if (!seen) begin
        n = n + 4'd1;
      end
    end
    return n;
  endfunction

  function automatic logic [3:0] byte_tz(input logic [7:0] b);
    logic [3:0] n;
    logic       seen;
    n    = 4'd0;
    seen = 1'b0;
    for (int i = 0; i < 8; i++) begin
      seen = seen | b[i];
      if (!seen) begin
        n = n + 4'd1;
      end
    end
    return n;
  endfunction

  function automatic logic [3:0] byte_pop(input logic [7:0] b);
    logic [3:0] n;
    n = 4'd0;
    for (int i = 0; i < 8; i++) begin
      n = n + {3'd0, b[i]};
    end
    return n;
  endfunction

  logic [4:0]         shamt;
  logic [63:0]        rot_l;
  logic [63:0]        rot_r;
  xoff_pkg::xlen_t    s1_res_d;
  logic [3:0][3:0]    lz_d;
  logic [3:0][3:0]    tz_d;
  logic [3:0][3:0]    pop_d;

  logic               s1_valid_q;
  xoff_pkg::bm_op_e   s1_op_q;
  xoff_pkg::reg_idx_t s1_rd_q;
  xoff_pkg::xlen_t    s1_res_q;
  logic [3:0][3:0]    s1_lz_q;
  logic [3:0][3:0]    s1_tz_q;
  logic [3:0][3:0]    s1_pop_q;

  logic [5:0]         clz_sum;
  logic [5:0]         ctz_sum;
  logic [5:0]         pop_sum;
  xoff_pkg::xlen_t    s2_res_d;

  // Doubled word turns both rotates into plain shifts
  assign shamt = b_i[4:0];
  assign rot_l = {a_i, a_i} << shamt;
  assign rot_r = {a_i, a_i} >> shamt;

  always_comb begin
    case (op_i)
      xoff_pkg::BM_ANDN: s1_res_d = a_i & ~b_i;
      xoff_pkg::BM_ORN:  s1_res_d = a_i | ~b_i;
      xoff_pkg::BM_XNOR: s1_res_d = ~(a_i ^ b_i);
      xoff_pkg::BM_MIN:  s1_res_d = ($signed(a_i) < $signed(b_i)) ? a_i : b_i;
      xoff_pkg::BM_MAX:  s1_res_d = ($signed(a_i) < $signed(b_i)) ? b_i : a_i;
      xoff_pkg::BM_MINU: s1_res_d = (a_i < b_i) ? a_i : b_i;
      xoff_pkg::BM_MAXU: s1_res_d = (a_i < b_i) ? b_i : a_i;
      xoff_pkg::BM_ROL:  s1_res_d = rot_l[63:32];
      xoff_pkg::BM_ROR:  s1_res_d = rot_r[31:0];
      xoff_pkg::BM_REV8: s1_res_d = {a_i[7:0], a_i[15:8], a_i[23:16], a_i[31:24]};
      default:           s1_res_d = '0;
    endcase
  end

  always_comb begin
    for (int i = 0; i < 4; i++) begin
      lz_d[i]  = byte_lz(a_i[8*i +: 8]);
      tz_d[i]  = byte_tz(a_i[8*i +: 8]);
      pop_d[i] = byte_pop(a_i[8*i +: 8]);
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      s1_valid_q <= 1'b0;
    end else begin
      s1_valid_q <= in_valid_i;
    end
  end

  always_ff @(posedge clk_i) begin
    s1_op_q  <= op_i;
    s1_rd_q  <= rd_i;
    s1_res_q <= s1_res_d;
    s1_lz_q  <= lz_d;
    s1_tz_q  <= tz_d;
    s1_pop_q <= pop_d;
  end

  // Stage 2, accumulate bytes until the first one that is not all zero
  always_comb begin
    logic done;
    clz_sum = 6'd0;
    done    = 1'b0;
    for (int i = 3; i >= 0; i--) begin
      if (!done) begin
        clz_sum = clz_sum + {2'd0, s1_lz_q[i]};
        done    = (s1_lz_q[i] != 4'd8);
      end
    end
  end

  always_comb begin
    logic done;
    ctz_sum = 6'd0;
    done    = 1'b0;
    for (int i = 0; i < 4; i++) begin
      if (!done) begin
        ctz_sum = ctz_sum + {2'd0, s1_tz_q[i]};
        done    = (s1_tz_q[i] != 4'd8);
      end
    end
  end

  assign pop_sum = {2'd0, s1_pop_q[0]} + {2'd0, s1_pop_q[1]}
                 + {2'd0, s1_pop_q[2]} + {2'd0, s1_pop_q[3]};

  always_comb begin
    case (s1_op_q)
      xoff_pkg::BM_CLZ:  s2_res_d = {26'd0, clz_sum};
      xoff_pkg::BM_CTZ:  s2_res_d = {26'd0, ctz_sum};
      xoff_pkg::BM_CPOP: s2_res_d = {26'd0, pop_sum};
      default:           s2_res_d = s1_res_q;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      out_valid_o <= 1'b0;
    end else begin
      out_valid_o <= s1_valid_q;
    end
  end

  always_ff @(posedge clk_i) begin
    out_rd_o   <= s1_rd_q;
    out_data_o <= s2_res_d;
  end

endmodule

`default_nettype wire

// File: design/xoff_result_buf.sv
/*
  Result FIFO of BUF_DEPTH entries in front of the response channel.
  The head entry is shown straight from storage, so a push is visible
  on p_valid_o one cycle later. There is no overflow handling. The
  upstream credit scheme must keep pushes away from a full FIFO.
  credit_ret_o pulses one cycle after each response transfer.
*/
`default_nettype none

module xoff_result_buf (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               push_i,
  input  xoff_pkg::reg_idx_t push_rd_i,
  input  xoff_pkg::xlen_t    push_data_i,
  output logic               p_valid_o,
  input  logic               p_ready_i,
  output xoff_pkg::reg_idx_t p_rd_o,
  output xoff_pkg::xlen_t    p_data_o,
  output logic               credit_ret_o
);

  localparam int PTR_W = $clog2(xoff_pkg::BUF_DEPTH);

  xoff_pkg::xlen_t    mem_data [xoff_pkg::BUF_DEPTH];
  xoff_pkg::reg_idx_t mem_rd   [xoff_pkg::BUF_DEPTH];
  logic [PTR_W-1:0]   wr_ptr_q;
  logic [PTR_W-1:0]   rd_ptr_q;
  xoff_pkg::credit_t  count_q;
  logic               full;
  logic               pop;

  assign full      = (count_q == xoff_pkg::credit_t'(xoff_pkg::BUF_DEPTH));
  assign p_valid_o = (count_q != '0);
  assign pop       = p_valid_o & p_ready_i;
  assign p_rd_o    = mem_rd[rd_ptr_q];
  assign p_data_o  = mem_data[rd_ptr_q];

  always_ff @(posedge clk_i) begin
    if (push_i) begin
      mem_data[wr_ptr_q] <= push_data_i;
      mem_rd[wr_ptr_q]   <= push_rd_i;
    end
  end

  // Depth is a power of two, so pointers simply wrap
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      wr_ptr_q     <= '0;
      rd_ptr_q     <= '0;
      count_q      <= '0;
      credit_ret_o <= 1'b0;
    end else begin
      if (push_i) begin
        wr_ptr_q <= wr_ptr_q + 1'b1;
      end
      if (pop) begin
        rd_ptr_q <= rd_ptr_q + 1'b1;
      end
      case ({push_i, pop})
        2'b10:   count_q <= count_q + 1'b1;
        2'b01:   count_q <= count_q - 1'b1;
        default: count_q <= count_q;
      endcase
      credit_ret_o <= pop;
    end
  end

  // Holds only if the adapter never lends out more than BUF_DEPTH credits
  a_no_overflow: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    !(push_i && full));

endmodule

`default_nettype wire

// File: design/xoff_top.sv
/*
  Zbb offload subsystem for an RV32 core extension port.
  With an empty FIFO and p_ready_i high, a response follows an accepted
  request by 4 cycles. Responses keep issue order. There is no error
  response, no memory offload and no second writeback.
*/
`default_nettype none

module xoff_top (
  input  logic               clk_i,
  input  logic               rst_n_i,
  input  logic               q_valid_i,
  output logic               q_ready_o,
  input  xoff_pkg::instr_t   q_instr_i,
  input  xoff_pkg::xlen_t    q_rs1_i,
  input  xoff_pkg::xlen_t    q_rs2_i,
  output logic               k_accept_o,
  output logic               k_writeback_o,
  output logic               p_valid_o,
  input  logic               p_ready_i,
  output xoff_pkg::reg_idx_t p_rd_o,
  output xoff_pkg::xlen_t    p_data_o
);

  logic               issue_valid;
  xoff_pkg::bm_op_e   issue_op;
  xoff_pkg::reg_idx_t issue_rd;
  xoff_pkg::xlen_t    issue_a;
  xoff_pkg::xlen_t    issue_b;

  logic               res_valid;
  xoff_pkg::reg_idx_t res_rd;
  xoff_pkg::xlen_t    res_data;

  logic               credit_ret;

  xoff_adapter u_adapter (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .q_valid_i     (q_valid_i),
    .q_ready_o     (q_ready_o),
    .q_instr_i     (q_instr_i),
    .q_rs1_i       (q_rs1_i),
    .q_rs2_i       (q_rs2_i),
    .k_accept_o    (k_accept_o),
    .k_writeback_o (k_writeback_o),
    .issue_valid_o (issue_valid),
    .issue_op_o    (issue_op),
    .issue_rd_o    (issue_rd),
    .issue_a_o     (issue_a),
    .issue_b_o     (issue_b),
    .credit_ret_i  (credit_ret)
  );

  xoff_bitmanip u_bitmanip (
    .clk_i       (clk_i),
    .rst_n_i     (rst_n_i),
    .in_valid_i  (issue_valid),
    .op_i        (issue_op),
    .rd_i        (issue_rd),
    .a_i         (issue_a),
    .b_i         (issue_b),
    .out_valid_o (res_valid),
    .out_rd_o    (res_rd),
    .out_data_o  (res_data)
  );

  xoff_result_buf u_result_buf (
    .clk_i        (clk_i),
    .rst_n_i      (rst_n_i),
    .push_i       (res_valid),
    .push_rd_i    (res_rd),
    .push_data_i  (res_data),
    .p_valid_o    (p_valid_o),
    .p_ready_i    (p_ready_i),
    .p_rd_o       (p_rd_o),
    .p_data_o     (p_data_o),
    .credit_ret_o (credit_ret)
  );

endmodule

`default_nettype wire

// File: test/xoff_ref_model.svh
/*
  Reference model of the Zbb subset, written from the ratified encodings.
  Operation indices are 0 andn, 1 orn, 2 xnor, 3 min, 4 max, 5 minu,
  6 maxu, 7 rol, 8 ror, 9 clz, 10 ctz, 11 cpop and 12 rev8.
  Included at compilation-unit scope ahead of the testbench module.
*/
`ifndef XOFF_REF_MODEL_SVH
`define XOFF_REF_MODEL_SVH

localparam int NUM_OPS = 13;

function automatic logic [31:0] encode_instr(input int op, input logic [4:0] rd,
                                             input logic [4:0] rs1, input logic [4:0] rs2);
  logic [31:0] w;
  case (op)
    0:  w = {7'b0100000, rs2, rs1, 3'b111, rd, 7'b0110011};
    1:  w = {7'b0100000, rs2, rs1, 3'b110, rd, 7'b0110011};
    2:  w = {7'b0100000, rs2, rs1, 3'b100, rd, 7'b0110011};
    3:  w = {7'b0000101, rs2, rs1, 3'b100, rd, 7'b0110011};
    4:  w = {7'b0000101, rs2, rs1, 3'b110, rd, 7'b0110011};
    5:  w = {7'b0000101, rs2, rs1, 3'b101, rd, 7'b0110011};
    6:  w = {7'b0000101, rs2, rs1, 3'b111, rd, 7'b0110011};
    7:  w = {7'b0110000, rs2, rs1, 3'b001, rd, 7'b0110011};
    8:  w = {7'b0110000, rs2, rs1, 3'b101, rd, 7'b0110011};
    // Unary forms keep the whole selector in the immediate
    9:  w = {12'h600, rs1, 3'b001, rd, 7'b0010011};
    10: w = {12'h601, rs1, 3'b001, rd, 7'b0010011};
    11: w = {12'h602, rs1, 3'b001, rd, 7'b0010011};
    12: w = {12'h698, rs1, 3'b101, rd, 7'b0010011};
    default: w = 32'd0;
  endcase
  return w;
endfunction

// A word is kept only if re-encoding its own fields gives the word back
function automatic int decode_instr(input logic [31:0] w);
  int op;
  op = -1;
  for (int i = 0; i < NUM_OPS; i++) begin
    if (w == encode_instr(i, w[11:7], w[19:15], w[24:20])) begin
      op = i;
    end
  end
  return op;
endfunction

function automatic logic [31:0] expected_result(input int op, input logic [31:0] a,
                                                input logic [31:0] b);
  logic [31:0] r;
  int          n;
  int          s;
  r = 32'd0;
  n = 0;
  s = int'(b[4:0]);
  case (op)
    0: r = a & ~b;
    1: r = a | ~b;
    2: r = ~(a ^ b);
    3: r = ($signed(a) < $signed(b)) ? a : b;
    4: r = ($signed(a) > $signed(b)) ? a : b;
    5: r = (a < b) ? a : b;
    6: r = (a > b) ? a : b;
    7: r = (s == 0) ? a : ((a << s) | (a >> (32 - s)));
    8: r = (s == 0) ? a : ((a >> s) | (a << (32 - s)));
    9: begin
      // Highest set bit wins
      n = 32;
      for (int i = 0; i < 32; i++) begin
        if (a[i]) n = 31 - i;
      end
      r = 32'(n);
    end
    10: begin
      n = 32;
      for (int i = 31; i >= 0; i--) begin
        if (a[i]) n = i;
      end
      r = 32'(n);
    end
    11: begin
      for (int i = 0; i < 32; i++) begin
        if (a[i]) n = n + 1;
      end
      r = 32'(n);
    end
    12: r = {a[7:0], a[15:8], a[23:16], a[31:24]};
    default: r = 32'd0;
  endcase
  return r;
endfunction

`endif

// File: test/xoff_tb.sv
/*
  Testbench for the Zbb offload top level.
  Expected results come from the reference model header.
  Stimulus comes from a seeded LCG, so every run repeats the same sequence.
  The first failed check stops the run.
*/
`default_nettype none

`include "xoff_ref_model.svh"

module xoff_tb;

  localparam int CLK_PERIOD  = 8;
  localparam int N_EDGE      = 6;
  localparam int N_RAND      = 300;
  localparam int N_TXN       = NUM_OPS * N_EDGE * N_EDGE + N_RAND + 8;
  localparam int DRAIN_LIMIT = 100;

  logic               clk = 1'b0;
  logic               rst_n = 1'b0;
  logic               q_valid = 1'b0;
  logic               q_ready;
  xoff_pkg::instr_t   q_instr = '0;
  xoff_pkg::xlen_t    q_rs1 = '0;
  xoff_pkg::xlen_t    q_rs2 = '0;
  logic               k_accept;
  logic               k_writeback;
  logic               p_valid;
  logic               p_ready = 1'b1;
  xoff_pkg::reg_idx_t p_rd;
  xoff_pkg::xlen_t    p_data;

  logic [31:0]        rng_state = 32'd73;
  logic               rand_ready = 1'b0;

  // Expected {rd, data} in issue order
  logic [36:0]        exp_q [$];
  int                 exp_credits = 0;
  int                 n_acc = 0;
  int                 n_resp = 0;
  int                 mon_op;
  logic [36:0]        head;
  logic               pop_d1 = 1'b0;
  logic               held = 1'b0;
  xoff_pkg::reg_idx_t held_rd;
  xoff_pkg::xlen_t    held_data;

  xoff_top UUT (
    .clk_i         (clk),
    .rst_n_i       (rst_n),
    .q_valid_i     (q_valid),
    .q_ready_o     (q_ready),
    .q_instr_i     (q_instr),
    .q_rs1_i       (q_rs1),
    .q_rs2_i       (q_rs2),
    .k_accept_o    (k_accept),
    .k_writeback_o (k_writeback),
    .p_valid_o     (p_valid),
    .p_ready_i     (p_ready),
    .p_rd_o        (p_rd),
    .p_data_o      (p_data)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic abort_run(input string why);
    $display("%s", why);
    $display("Done: errors found");
    $fatal(1, "simulation stopped at the first error");
  endtask

  task automatic report_value(input string name, input logic [31:0] got,
                              input logic [31:0] exp);
    abort_run($sformatf("ERR %s got 0x%h expected 0x%h", name, got, exp));
  endtask

  function automatic logic [31:0] rand32();
    rng_state = rng_state * 32'd1664525 + 32'd1013904223;
    return rng_state;
  endfunction

  function automatic logic [31:0] edge_operand(input int i);
    case (i)
      0:       return 32'h0000_0000;
      1:       return 32'hFFFF_FFFF;
      2:       return 32'h7FFF_FFFF;
      3:       return 32'h8000_0000;
      4:       return 32'h0000_001F;
      default: return 32'h0000_0001;
    endcase
  endfunction

  // Mostly random words with an edge value now and then
  function automatic logic [31:0] pick_operand();
    logic [31:0] x;
    x = rand32();
    if (x[31:29] == 3'd0) begin
      return edge_operand(int'(x[2:0]) % N_EDGE);
    end
    return rand32();
  endfunction

  task automatic tick();
    logic [31:0] x;
    @(posedge clk);
    if (rand_ready) begin
      x = rand32();
      p_ready <= (x[31:30] != 2'b00);
    end
  endtask

  // Returns at the edge where the transfer took place
  task automatic send_req(input xoff_pkg::instr_t instr, input xoff_pkg::xlen_t a,
                          input xoff_pkg::xlen_t b);
    q_valid <= 1'b1;
    q_instr <= instr;
    q_rs1   <= a;
    q_rs2   <= b;
    tick();
    while (!q_ready) tick();
  endtask

  task automatic drain();
    int waited;
    waited = 0;
    q_valid <= 1'b0;
    tick();
    while (exp_q.size() != 0 && waited < DRAIN_LIMIT) begin
      tick();
      waited = waited + 1;
    end
    repeat (3) tick();
  endtask

  // Response and credit monitor
  always @(posedge clk) begin
    if (!rst_n) begin
      exp_credits = xoff_pkg::BUF_DEPTH;
      pop_d1      = 1'b0;
      held        = 1'b0;
    end else begin
      assert (q_ready == (exp_credits != 0))
        else report_value("q_ready_o", 32'(q_ready), 32'(exp_credits != 0));
      if (q_valid && q_ready) begin
        mon_op = decode_instr(q_instr);
        assert (k_accept == (mon_op >= 0))
          else report_value("k_accept_o", 32'(k_accept), 32'(mon_op >= 0));
        assert (k_writeback == (mon_op >= 0))
          else report_value("k_writeback_o", 32'(k_writeback), 32'(mon_op >= 0));
        if (mon_op >= 0) begin
          exp_q.push_back({q_instr[11:7], expected_result(mon_op, q_rs1, q_rs2)});
          exp_credits = exp_credits - 1;
          n_acc = n_acc + 1;
        end
      end
      // A stalled response must not move
      if (held) begin
        assert (p_valid) else abort_run("p_valid_o dropped while p_ready_i was low");
        assert (p_rd == held_rd) else report_value("p_rd_o", 32'(p_rd), 32'(held_rd));
        assert (p_data == held_data) else report_value("p_data_o", p_data, held_data);
      end
      if (p_valid && p_ready) begin
        assert (exp_q.size() != 0) else abort_run("response without an accepted request");
        head = exp_q.pop_front();
        assert (p_rd == head[36:32]) else report_value("p_rd_o", 32'(p_rd), 32'(head[36:32]));
        assert (p_data == head[31:0]) else report_value("p_data_o", p_data, head[31:0]);
        n_resp = n_resp + 1;
      end
      // Returned credit shows on q_ready_o two edges after the pop
      if (pop_d1) exp_credits = exp_credits + 1;
      pop_d1    = p_valid && p_ready;
      held      = p_valid && !p_ready;
      held_rd   = p_rd;
      held_data = p_data;
    end
  end

  initial begin
    #(CLK_PERIOD * (N_TXN * 20 + 200));
    abort_run("watchdog timeout, the run did not finish in time");
  end

  initial begin
    xoff_pkg::instr_t instr;
    logic [31:0]      x;
    int               lat;
    repeat (2) @(posedge clk);
    rst_n <= 1'b1;
    tick();
    assert (q_ready && !p_valid) else abort_run("q_ready_o low or p_valid_o high after reset");

    // One cpop into an idle path
    x = rand32();
    send_req(encode_instr(11, x[31:27], x[26:22], x[21:17]), rand32(), rand32());
    q_valid <= 1'b0;
    lat = 0;
    do begin
      tick();
      lat = lat + 1;
    end while (!p_valid && lat < 10);
    assert (lat == 4) else report_value("response latency", 32'(lat), 32'd4);
    drain();

    // Every operation on every pair of edge operands, back to back
    for (int op = 0; op < NUM_OPS; op++) begin
      for (int i = 0; i < N_EDGE; i++) begin
        for (int j = 0; j < N_EDGE; j++) begin
          x = rand32();
          send_req(encode_instr(op, x[31:27], x[26:22], x[21:17]),
                   edge_operand(i), edge_operand(j));
        end
      end
    end
    drain();

    // Kept, near-miss and unrelated words with random back-pressure
    rand_ready = 1'b1;
    for (int t = 0; t < N_RAND; t++) begin
      x     = rand32();
      instr = encode_instr(int'(rand32() % 32'd13), x[31:27], x[26:22], x[21:17]);
      if (x[3:0] >= 4'd13) begin
        instr = rand32();
      end else if (x[3:0] >= 4'd10) begin
        instr = instr ^ (32'd1 << x[16:12]);
      end
      send_req(instr, pick_operand(), pick_operand());
    end
    drain();
    rand_ready = 1'b0;

    // Fill the FIFO with p_ready_i low and hold one more request
    p_ready <= 1'b0;
    for (int k = 0; k < xoff_pkg::BUF_DEPTH; k++) begin
      x = rand32();
      send_req(encode_instr(k, x[31:27], x[26:22], x[21:17]), rand32(), rand32());
    end
    x = rand32();
    q_valid <= 1'b1;
    q_instr <= encode_instr(7, x[31:27], x[26:22], x[21:17]);
    q_rs1   <= rand32();
    q_rs2   <= rand32();
    repeat (8) tick();
    assert (!q_ready) else abort_run("q_ready_o high while the FIFO is full");
    p_ready <= 1'b1;
    tick();
    while (!q_ready) tick();
    drain();

    if (exp_q.size() == 0 && n_resp == n_acc) begin
      $display("Done: no errors");
      $finish;
    end else begin
      abort_run("responses missing at the end of the run");
    end
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+test
design/xoff_pkg.sv
design/xoff_predecoder.sv
design/xoff_adapter.sv
design/xoff_bitmanip.sv
design/xoff_result_buf.sv
design/xoff_top.sv
test/xoff_tb.sv

// File: Makefile
# Verilator build and run of the Zbb offload testbench
# Any variable can be overridden, e.g. make sim BUILD_DIR=build

VERILATOR ?= verilator
TOP       ?= xoff_tb
FILELIST  ?= list.f
BUILD_DIR ?= obj_dir
JOBS      ?= 0
VFLAGS    ?= --binary --timing --assert

.PHONY: sim clean

# A $fatal in the testbench gives a nonzero exit status
sim:
	$(VERILATOR) $(VFLAGS) -j $(JOBS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP)

clean:
	rm -rf $(BUILD_DIR)
